//--- include/mem_bank_settings.svh
/* Local memory bank widths and sizes */

`ifndef MEM_BANK_SETTINGS_SVH
`define MEM_BANK_SETTINGS_SVH

// Byte address width seen on both accelerator ports
`define MEM_BANK_ADDR_W 16

// Data word width, a whole number of bytes
`define MEM_BANK_DATA_W 32

// AXI transaction id width, echoed back on b and r
`define MEM_BANK_ID_W 4

// Words in the array, so byte addresses from 1024 up are out of range
`define MEM_BANK_WORDS 256

// Accelerator ports sharing the single bank
`define MEM_BANK_NUM_PORTS 2

`endif

//--- logic/mem_bank_pkg.sv
/* Local memory bank types */

`default_nettype none

`include "mem_bank_settings.svh"

package mem_bank_pkg;

    // Plain vectors for the widths that carry a meaning
    typedef logic [`MEM_BANK_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_BANK_DATA_W-1:0] data_t;
    typedef logic [`MEM_BANK_DATA_W/8-1:0] strb_t;
    typedef logic [`MEM_BANK_ID_W-1:0] id_t;
    typedef logic [1:0] resp_t;
    typedef logic [$clog2(`MEM_BANK_NUM_PORTS)-1:0] src_t;

    // AXI response codes, only these two are ever produced
    localparam resp_t resp_okay = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

    // Single beat AXI channel payloads, burst fields dropped
    typedef struct packed {
        id_t id;
        addr_t addr;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        id_t id;
        addr_t addr;
    } axi_ar_t;

    typedef struct packed {
        id_t id;
        resp_t resp;
    } axi_b_t;

    typedef struct packed {
        id_t id;
        data_t data;
        resp_t resp;
    } axi_r_t;

    // Bank side view, one command carries either a read or a joined write
    typedef struct packed {
        logic write;
        id_t id;
        addr_t addr;
        data_t data;
        strb_t strb;
    } bank_cmd_t;

    typedef struct packed {
        logic write;
        id_t id;
        data_t data;
        resp_t resp;
    } bank_rsp_t;

endpackage

`default_nettype wire

//--- logic/mem_bank_port_map.sv
/* AXI port to bank command mapping */

`timescale 1ns/1ps
`default_nettype none

module mem_bank_port_map
(
    input  wire logic fim_mem_bank,
    input  wire logic rst_n,

    input  wire logic aw_valid,
    input  mem_bank_pkg::axi_aw_t aw,
    output logic aw_ready,

    input  wire logic w_valid,
    input  mem_bank_pkg::axi_w_t w,
    output logic w_ready,

    output logic b_valid,
    output mem_bank_pkg::axi_b_t b,
    input  wire logic b_ready,

    input  wire logic ar_valid,
    input  mem_bank_pkg::axi_ar_t ar,
    output logic ar_ready,

    output logic r_valid,
    output mem_bank_pkg::axi_r_t r,
    input  wire logic r_ready,

    output logic cmd_valid,
    output mem_bank_pkg::bank_cmd_t cmd,
    input  wire logic cmd_ready,

    input  wire logic rsp_valid,
    input  mem_bank_pkg::bank_rsp_t rsp,
    output logic rsp_ready
);

    // A write is only offered once address and data are both present
    logic wr_pend;
    logic rd_pend;
    logic sel_wr;
    // Set when the last accepted command was a read, reset means write
    logic last_op_rd;

    assign wr_pend = aw_valid & w_valid;
    assign rd_pend = ar_valid;

    // On a tie take the opposite of the previous accepted kind
    assign sel_wr = wr_pend & (~rd_pend | last_op_rd);

    assign cmd_valid = wr_pend | rd_pend;

    always_comb
    begin
        cmd = '0;
        cmd.write = sel_wr;
        if (sel_wr)
        begin
            cmd.id = aw.id;
            cmd.addr = aw.addr;
            cmd.data = w.data;
            cmd.strb = w.strb;
        end
        else
        begin
            cmd.id = ar.id;
            cmd.addr = ar.addr;
        end
    end

    // Address and data of a write leave in the same cycle as the command
    assign aw_ready = cmd_ready & sel_wr;
    assign w_ready = cmd_ready & sel_wr;
    assign ar_ready = cmd_ready & rd_pend & ~sel_wr;

    always_ff @(posedge fim_mem_bank or negedge rst_n)
    begin
        if (!rst_n)
        begin
            last_op_rd <= 1'b0;
        end
        else if (cmd_valid && cmd_ready)
        begin
            last_op_rd <= ~sel_wr;
        end
    end

    // Split the bank response by its write flag
    assign b_valid = rsp_valid & rsp.write;
    assign r_valid = rsp_valid & ~rsp.write;
    assign b.id = rsp.id;
    assign b.resp = rsp.resp;
    assign r.id = rsp.id;
    assign r.data = rsp.data;
    assign r.resp = rsp.resp;

    assign rsp_ready = rsp.write ? b_ready : r_ready;

endmodule

`default_nettype wire

//--- logic/mem_bank_arbiter.sv
/* Round-robin bank arbiter */

`timescale 1ns/1ps
`default_nettype none

`include "mem_bank_settings.svh"

module mem_bank_arbiter
(
    input  wire logic fim_mem_bank,
    input  wire logic rst_n,

    // Command side of each port map
    input  wire logic [`MEM_BANK_NUM_PORTS-1:0] cmd_valid,
    input  mem_bank_pkg::bank_cmd_t cmd [`MEM_BANK_NUM_PORTS],
    output logic [`MEM_BANK_NUM_PORTS-1:0] cmd_ready,

    // Response side of each port map
    output logic [`MEM_BANK_NUM_PORTS-1:0] rsp_valid,
    output mem_bank_pkg::bank_rsp_t rsp [`MEM_BANK_NUM_PORTS],
    input  wire logic [`MEM_BANK_NUM_PORTS-1:0] rsp_ready,

    // Single bank
    output logic bank_cmd_valid,
    output mem_bank_pkg::bank_cmd_t bank_cmd,
    output mem_bank_pkg::src_t bank_src,
    input  wire logic bank_cmd_ready,
    input  wire logic bank_rsp_valid,
    input  mem_bank_pkg::bank_rsp_t bank_rsp,
    input  mem_bank_pkg::src_t bank_rsp_src,
    output logic bank_rsp_ready
);

    // Port that wins a tie
    mem_bank_pkg::src_t prio;
    mem_bank_pkg::src_t other;
    mem_bank_pkg::src_t grant;
    logic accept;

    assign other = ~prio;

    // Favoured port if it asks, else the other one
    // With nobody asking the grant simply rests on the favoured port
    assign grant = (cmd_valid[prio] || !cmd_valid[other]) ? prio : other;

    assign bank_cmd_valid = |cmd_valid;
    assign bank_cmd = cmd[grant];
    assign bank_src = grant;
    assign accept = bank_cmd_valid & bank_cmd_ready;

    always_comb
    begin
        for (int i = 0; i < `MEM_BANK_NUM_PORTS; i++)
        begin
            cmd_ready[i] = bank_cmd_ready & (grant == mem_bank_pkg::src_t'(i));
        end
    end

    // Priority turns over after each accepted command
    // While a command stalls the priority is parked on it, so that a
    // request arriving later on the other port cannot steal the grant
    always_ff @(posedge fim_mem_bank or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prio <= '0;
        end
        else if (accept)
        begin
            prio <= ~grant;
        end
        else if (bank_cmd_valid)
        begin
            prio <= grant;
        end
    end

    // Response fans out to all maps, only the source port sees it valid
    always_comb
    begin
        for (int i = 0; i < `MEM_BANK_NUM_PORTS; i++)
        begin
            rsp_valid[i] = bank_rsp_valid & (bank_rsp_src == mem_bank_pkg::src_t'(i));
            rsp[i] = bank_rsp;
        end
    end

    assign bank_rsp_ready = rsp_ready[bank_rsp_src];

endmodule

`default_nettype wire

//--- logic/mem_bank_array.sv
/* Local memory word array */

`timescale 1ns/1ps
`default_nettype none

`include "mem_bank_settings.svh"

module mem_bank_array
(
    input  wire logic fim_mem_bank,
    input  wire logic rst_n,

    input  wire logic cmd_valid,
    input  mem_bank_pkg::bank_cmd_t cmd,
    input  mem_bank_pkg::src_t src,
    output logic cmd_ready,

    output logic rsp_valid,
    output mem_bank_pkg::bank_rsp_t rsp,
    output mem_bank_pkg::src_t rsp_src,
    input  wire logic rsp_ready
);

    localparam int IDX_W = $clog2(`MEM_BANK_WORDS);
    localparam int NUM_BYTES = `MEM_BANK_DATA_W / 8;

    mem_bank_pkg::data_t mem [`MEM_BANK_WORDS];

    logic [IDX_W-1:0] idx;
    logic in_range;
    logic accept;

    // Word index drops the two byte offset bits
    assign idx = cmd.addr[IDX_W+1:2];
    assign in_range = cmd.addr < mem_bank_pkg::addr_t'(`MEM_BANK_WORDS * 4);

    // Only one response is held, a new command waits until it leaves
    assign cmd_ready = ~rsp_valid | rsp_ready;
    assign accept = cmd_valid & cmd_ready;

    // Byte strobed write, nothing is stored for an out of range address
    always_ff @(posedge fim_mem_bank)
    begin
        if (accept && cmd.write && in_range)
        begin
            for (int i = 0; i < NUM_BYTES; i++)
            begin
                if (cmd.strb[i])
                begin
                    mem[idx][8*i +: 8] <= cmd.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge fim_mem_bank or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rsp_valid <= 1'b0;
        end
        else if (accept)
        begin
            rsp_valid <= 1'b1;
        end
        else if (rsp_ready)
        begin
            rsp_valid <= 1'b0;
        end
    end

    // Response payload is loaded with the command, one cycle later it is valid
    always_ff @(posedge fim_mem_bank)
    begin
        if (accept)
        begin
            rsp.write <= cmd.write;
            rsp.id <= cmd.id;
            rsp.data <= (!cmd.write && in_range) ? mem[idx] : '0;
            rsp.resp <= in_range ? mem_bank_pkg::resp_okay : mem_bank_pkg::resp_slverr;
            rsp_src <= src;
        end
    end

endmodule

`default_nettype wire

//--- logic/local_mem_top.sv
/* Shared local memory top */

`timescale 1ns/1ps
`default_nettype none

`include "mem_bank_settings.svh"

module local_mem_top
(
    input  wire logic fim_mem_bank,
    input  wire logic rst_n,

    input  wire logic [`MEM_BANK_NUM_PORTS-1:0] aw_valid,
    input  mem_bank_pkg::axi_aw_t aw [`MEM_BANK_NUM_PORTS],
    output logic [`MEM_BANK_NUM_PORTS-1:0] aw_ready,
    input  wire logic [`MEM_BANK_NUM_PORTS-1:0] w_valid,
    input  mem_bank_pkg::axi_w_t w [`MEM_BANK_NUM_PORTS],
    output logic [`MEM_BANK_NUM_PORTS-1:0] w_ready,
    output logic [`MEM_BANK_NUM_PORTS-1:0] b_valid,
    output mem_bank_pkg::axi_b_t b [`MEM_BANK_NUM_PORTS],
    input  wire logic [`MEM_BANK_NUM_PORTS-1:0] b_ready,
    input  wire logic [`MEM_BANK_NUM_PORTS-1:0] ar_valid,
    input  mem_bank_pkg::axi_ar_t ar [`MEM_BANK_NUM_PORTS],
    output logic [`MEM_BANK_NUM_PORTS-1:0] ar_ready,
    output logic [`MEM_BANK_NUM_PORTS-1:0] r_valid,
    output mem_bank_pkg::axi_r_t r [`MEM_BANK_NUM_PORTS],
    input  wire logic [`MEM_BANK_NUM_PORTS-1:0] r_ready
);

    // Map to arbiter
    logic [`MEM_BANK_NUM_PORTS-1:0] cmd_valid;
    mem_bank_pkg::bank_cmd_t cmd [`MEM_BANK_NUM_PORTS];
    logic [`MEM_BANK_NUM_PORTS-1:0] cmd_ready;
    logic [`MEM_BANK_NUM_PORTS-1:0] rsp_valid;
    mem_bank_pkg::bank_rsp_t rsp [`MEM_BANK_NUM_PORTS];
    logic [`MEM_BANK_NUM_PORTS-1:0] rsp_ready;

    // Arbiter to array
    logic bank_cmd_valid;
    mem_bank_pkg::bank_cmd_t bank_cmd;
    mem_bank_pkg::src_t bank_src;
    logic bank_cmd_ready;
    logic bank_rsp_valid;
    mem_bank_pkg::bank_rsp_t bank_rsp;
    mem_bank_pkg::src_t bank_rsp_src;
    logic bank_rsp_ready;

    mem_bank_port_map map0
    (
        .fim_mem_bank(fim_mem_bank), .rst_n(rst_n),
        .aw_valid(aw_valid[0]), .aw(aw[0]), .aw_ready(aw_ready[0]),
        .w_valid(w_valid[0]), .w(w[0]), .w_ready(w_ready[0]),
        .b_valid(b_valid[0]), .b(b[0]), .b_ready(b_ready[0]),
        .ar_valid(ar_valid[0]), .ar(ar[0]), .ar_ready(ar_ready[0]),
        .r_valid(r_valid[0]), .r(r[0]), .r_ready(r_ready[0]),
        .cmd_valid(cmd_valid[0]), .cmd(cmd[0]), .cmd_ready(cmd_ready[0]),
        .rsp_valid(rsp_valid[0]), .rsp(rsp[0]), .rsp_ready(rsp_ready[0])
    );

    mem_bank_port_map map1
    (
        .fim_mem_bank(fim_mem_bank), .rst_n(rst_n),
        .aw_valid(aw_valid[1]), .aw(aw[1]), .aw_ready(aw_ready[1]),
        .w_valid(w_valid[1]), .w(w[1]), .w_ready(w_ready[1]),
        .b_valid(b_valid[1]), .b(b[1]), .b_ready(b_ready[1]),
        .ar_valid(ar_valid[1]), .ar(ar[1]), .ar_ready(ar_ready[1]),
        .r_valid(r_valid[1]), .r(r[1]), .r_ready(r_ready[1]),
        .cmd_valid(cmd_valid[1]), .cmd(cmd[1]), .cmd_ready(cmd_ready[1]),
        .rsp_valid(rsp_valid[1]), .rsp(rsp[1]), .rsp_ready(rsp_ready[1])
    );

    mem_bank_arbiter arb0
    (
        .fim_mem_bank(fim_mem_bank), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
        .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready),
        .bank_cmd_valid(bank_cmd_valid), .bank_cmd(bank_cmd), .bank_src(bank_src),
        .bank_cmd_ready(bank_cmd_ready),
        .bank_rsp_valid(bank_rsp_valid), .bank_rsp(bank_rsp),
        .bank_rsp_src(bank_rsp_src), .bank_rsp_ready(bank_rsp_ready)
    );

    mem_bank_array array0
    (
        .fim_mem_bank(fim_mem_bank), .rst_n(rst_n),
        .cmd_valid(bank_cmd_valid), .cmd(bank_cmd), .src(bank_src),
        .cmd_ready(bank_cmd_ready),
        .rsp_valid(bank_rsp_valid), .rsp(bank_rsp), .rsp_src(bank_rsp_src),
        .rsp_ready(bank_rsp_ready)
    );

endmodule

`default_nettype wire

//--- test/local_mem_assertions.sv
/* Bank array handshake checks */

`timescale 1ns/1ps
`default_nettype none

module local_mem_assertions
(
    input  wire logic fim_mem_bank,
    input  wire logic rst_n,
    input  wire logic cmd_valid,
    input  wire logic cmd_ready,
    input  wire logic rsp_valid,
    input  mem_bank_pkg::bank_rsp_t rsp,
    input  wire logic rsp_ready
);

    // Running total of failed assertions
    int fail_count = 0;

    // Commands accepted minus responses taken, counted from the handshakes alone
    logic [1:0] open_cnt;

    always_ff @(posedge fim_mem_bank or negedge rst_n)
    begin
        if (!rst_n)
        begin
            open_cnt <= 2'd0;
        end
        else if (cmd_valid && cmd_ready && !(rsp_valid && rsp_ready))
        begin
            open_cnt <= open_cnt + 2'd1;
        end
        else if (!(cmd_valid && cmd_ready) && rsp_valid && rsp_ready)
        begin
            open_cnt <= open_cnt - 2'd1;
        end
    end

    // The array comes out of reset with no response held
    reset_clears_rsp: assert property (@(posedge fim_mem_bank) $rose(rst_n) |-> !rsp_valid)
    else
    begin
        fail_count++;
        $error("rsp_valid high when reset was released");
    end

    // A stalled response keeps its payload until it is taken
    rsp_held_stable: assert property (@(posedge fim_mem_bank) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else
    begin
        fail_count++;
        $error("bank response changed or dropped while stalled");
    end

    // Only one response is ever held in the array
    no_cmd_over_held_rsp: assert property (@(posedge fim_mem_bank) disable iff (!rst_n)
        cmd_valid && cmd_ready |-> open_cnt == 2'd0 || (rsp_valid && rsp_ready))
    else
    begin
        fail_count++;
        $error("command accepted while a response was held");
    end

endmodule

`default_nettype wire

//--- test/local_mem_tb.sv
/* Local memory testbench */

`timescale 1ns/1ps
`default_nettype none

`include "mem_bank_settings.svh"

module local_mem_tb;

    // One table row is a single AXI transaction, par launches it with the next row
    typedef struct packed {
        mem_bank_pkg::src_t port;
        logic wr;
        logic par;
        mem_bank_pkg::addr_t addr;
        mem_bank_pkg::data_t data;
        mem_bank_pkg::strb_t strb;
        mem_bank_pkg::id_t id;
        mem_bank_pkg::data_t exp_data;
        mem_bank_pkg::resp_t exp_resp;
    } entry_t;

    localparam int idx_w = $clog2(`MEM_BANK_WORDS);
    localparam mem_bank_pkg::addr_t addr_limit = mem_bank_pkg::addr_t'(`MEM_BANK_WORDS * 4);

    logic fim_mem_bank;
    logic rst_n;
    logic [`MEM_BANK_NUM_PORTS-1:0] aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic [`MEM_BANK_NUM_PORTS-1:0] ar_valid, ar_ready, r_valid, r_ready;
    mem_bank_pkg::axi_aw_t aw [`MEM_BANK_NUM_PORTS];
    mem_bank_pkg::axi_w_t w [`MEM_BANK_NUM_PORTS];
    mem_bank_pkg::axi_b_t b [`MEM_BANK_NUM_PORTS];
    mem_bank_pkg::axi_ar_t ar [`MEM_BANK_NUM_PORTS];
    mem_bank_pkg::axi_r_t r [`MEM_BANK_NUM_PORTS];

    entry_t tab [$];
    // Expected memory contents, built up in table order
    mem_bank_pkg::data_t model [`MEM_BANK_WORDS];
    int issued [`MEM_BANK_NUM_PORTS];
    int resp_count [`MEM_BANK_NUM_PORTS];
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic built;
    logic [7:0] lfsr;

    local_mem_top dut0
    (
        .fim_mem_bank(fim_mem_bank), .rst_n(rst_n),
        .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
        .w_valid(w_valid), .w(w), .w_ready(w_ready),
        .b_valid(b_valid), .b(b), .b_ready(b_ready),
        .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
        .r_valid(r_valid), .r(r), .r_ready(r_ready)
    );

    bind mem_bank_array local_mem_assertions asserts0
    (
        .fim_mem_bank(fim_mem_bank), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready)
    );

    initial
    begin
        fim_mem_bank = 1'b0;
        forever #4 fim_mem_bank = ~fim_mem_bank;
    end

    // Taps 8, 6, 5 and 4 give a maximal length sequence
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // Appends a row and works out its expected response from the model
    task automatic add_entry(input logic par, input mem_bank_pkg::src_t port, input logic wr,
                             input mem_bank_pkg::addr_t addr, input mem_bank_pkg::data_t data,
                             input mem_bank_pkg::strb_t strb);
        entry_t e;
        e.par = par;
        e.port = port;
        e.wr = wr;
        e.addr = addr;
        e.data = data;
        e.strb = strb;
        e.id = mem_bank_pkg::id_t'(tab.size());
        e.exp_data = '0;
        e.exp_resp = (addr >= addr_limit) ? mem_bank_pkg::resp_slverr : mem_bank_pkg::resp_okay;
        // Out of range rows leave the model alone and read back zero
        if (addr < addr_limit)
        begin
            if (wr)
            begin
                for (int j = 0; j < `MEM_BANK_DATA_W / 8; j++)
                begin
                    if (strb[j])
                        model[addr[idx_w+1:2]][8*j +: 8] = data[8*j +: 8];
                end
            end
            else
                e.exp_data = model[addr[idx_w+1:2]];
        end
        issued[port]++;
        tab.push_back(e);
    endtask

    task automatic build_table();
        // Write then read back on one port, word 0 is later probed for aliasing
        add_entry(1'b0, 1'b0, 1'b1, 16'h0000, 32'hdeadbeef, 4'hf);
        add_entry(1'b0, 1'b0, 1'b1, 16'h0010, 32'h11223344, 4'hf);
        add_entry(1'b0, 1'b0, 1'b0, 16'h0010, '0, '0);
        // Partial strobes merged over full words
        add_entry(1'b0, 1'b1, 1'b1, 16'h0020, 32'haabbccdd, 4'hf);
        add_entry(1'b0, 1'b1, 1'b1, 16'h0020, 32'h55667788, 4'b0101);
        add_entry(1'b0, 1'b1, 1'b1, 16'h0024, 32'h01020304, 4'hf);
        add_entry(1'b0, 1'b1, 1'b1, 16'h0024, 32'hf0e0d0c0, 4'b1000);
        add_entry(1'b0, 1'b1, 1'b0, 16'h0020, '0, '0);
        add_entry(1'b0, 1'b0, 1'b0, 16'h0024, '0, '0);
        // Out of range; 0x400 would alias word 0 if the range check failed
        add_entry(1'b0, 1'b0, 1'b1, 16'h0400, 32'h0badf00d, 4'hf);
        add_entry(1'b0, 1'b0, 1'b0, 16'h0400, '0, '0);
        add_entry(1'b0, 1'b1, 1'b1, 16'hfffc, 32'h12345678, 4'hf);
        add_entry(1'b0, 1'b1, 1'b0, 16'h8000, '0, '0);
        add_entry(1'b0, 1'b0, 1'b0, 16'h0000, '0, '0);
        add_entry(1'b0, 1'b1, 1'b0, 16'h0010, '0, '0);
        // Both ports at once, each reads back what the other one wrote
        for (int i = 0; i < 8; i++)
        begin
            add_entry(1'b1, 1'b0, 1'b1, mem_bank_pkg::addr_t'(256 + 4 * i),
                      mem_bank_pkg::data_t'(32'h5a000000 + i * 257), 4'hf);
            add_entry(1'b0, 1'b1, 1'b1, mem_bank_pkg::addr_t'(512 + 4 * i),
                      mem_bank_pkg::data_t'(32'hc3000000 + i * 4099), 4'hf);
        end
        for (int i = 0; i < 8; i++)
        begin
            add_entry(1'b1, 1'b0, 1'b0, mem_bank_pkg::addr_t'(512 + 4 * i), '0, '0);
            add_entry(1'b0, 1'b1, 1'b0, mem_bank_pkg::addr_t'(256 + 4 * i), '0, '0);
        end
        // Read and write presented together on one port
        add_entry(1'b1, 1'b0, 1'b1, 16'h0300, 32'h0f1e2d3c, 4'hf);
        add_entry(1'b0, 1'b0, 1'b0, 16'h0104, '0, '0);
        add_entry(1'b1, 1'b1, 1'b0, 16'h0108, '0, '0);
        add_entry(1'b0, 1'b1, 1'b1, 16'h0304, 32'h4b5a6978, 4'hf);
        add_entry(1'b1, 1'b0, 1'b0, 16'h0304, '0, '0);
        add_entry(1'b0, 1'b1, 1'b0, 16'h0300, '0, '0);
    endtask

    task automatic compare_field(input string name, input mem_bank_pkg::src_t port,
                                 input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: port %0d %s = %h, expected %h",
                     $time, port, name, got, exp);
        end
    endtask

    // Drives one request, holds it to the handshake, then checks its response
    task automatic run_txn(input int k);
        entry_t e;
        mem_bank_pkg::src_t p;
        e = tab[k];
        p = e.port;
        @(negedge fim_mem_bank);
        if (e.wr)
        begin
            aw[p].id = e.id;
            aw[p].addr = e.addr;
            w[p].data = e.data;
            w[p].strb = e.strb;
            aw_valid[p] = 1'b1;
            w_valid[p] = 1'b1;
        end
        else
        begin
            ar[p].id = e.id;
            ar[p].addr = e.addr;
            ar_valid[p] = 1'b1;
        end
        // Sampled 1 ns after the falling edge, when every input has settled
        #1;
        while (e.wr ? !(aw_ready[p] && w_ready[p]) : !ar_ready[p])
        begin
            @(negedge fim_mem_bank);
            #1;
        end
        @(negedge fim_mem_bank);
        if (e.wr)
        begin
            aw_valid[p] = 1'b0;
            w_valid[p] = 1'b0;
        end
        else
            ar_valid[p] = 1'b0;
        #1;
        while (e.wr ? !(b_valid[p] && b_ready[p]) : !(r_valid[p] && r_ready[p]))
        begin
            @(negedge fim_mem_bank);
            #1;
        end
        if (e.wr)
        begin
            compare_field("b.id", p, 32'(b[p].id), 32'(e.id));
            compare_field("b.resp", p, 32'(b[p].resp), 32'(e.exp_resp));
        end
        else
        begin
            compare_field("r.id", p, 32'(r[p].id), 32'(e.id));
            compare_field("r.data", p, r[p].data, e.exp_data);
            compare_field("r.resp", p, 32'(r[p].resp), 32'(e.exp_resp));
        end
    endtask

    // Random response back-pressure and a count of every response handshake
    initial
    begin
        logic [3:0] bits;
        logic [1:0] hs;
        lfsr = 8'd62;
        bits = '0;
        b_ready = '0;
        r_ready = '0;
        forever
        begin
            @(negedge fim_mem_bank);
            for (int i = 0; i < 4; i++)
            begin
                lfsr = lfsr_step(lfsr);
                bits = {bits[2:0], lfsr[0]};
            end
            b_ready = bits[1:0];
            r_ready = bits[3:2];
            #1;
            hs = (b_valid & b_ready) | (r_valid & r_ready);
            if (hs[0])
                resp_count[0]++;
            if (hs[1])
                resp_count[1]++;
        end
    end

    // Each row may take up to 64 cycles
    initial
    begin
        wait (built);
        while (cycles < 64 * tab.size())
        begin
            @(posedge fim_mem_bank);
            cycles++;
        end
        $display("Timeout after %0d cycles, a transaction never completed", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        int k;
        built = 1'b0;
        rst_n = 1'b0;
        aw_valid = '0;
        w_valid = '0;
        ar_valid = '0;
        aw = '{default: '0};
        w = '{default: '0};
        ar = '{default: '0};
        build_table();
        built = 1'b1;
        repeat (16) @(negedge fim_mem_bank);
        rst_n = 1'b1;
        k = 0;
        while (k < tab.size())
        begin
            if (tab[k].par && k + 1 < tab.size())
            begin
                fork
                    run_txn(k);
                    run_txn(k + 1);
                join
                k = k + 2;
            end
            else
            begin
                run_txn(k);
                k = k + 1;
            end
        end
        // A few idle cycles so a duplicated response would still be counted
        repeat (4) @(negedge fim_mem_bank);
        compare_field("response count", 1'b0, resp_count[0], issued[0]);
        compare_field("response count", 1'b1, resp_count[1], issued[1]);
        if (dut0.array0.asserts0.fail_count != 0)
        begin
            errors = errors + dut0.array0.asserts0.fail_count;
            $display("Concurrent assertions failed %0d times", dut0.array0.asserts0.fail_count);
        end
        $display("Transactions: %0d, checks: %0d, errors: %0d", tab.size(), checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- local_mem_top.f
+incdir+include
logic/mem_bank_pkg.sv
logic/mem_bank_port_map.sv
logic/mem_bank_arbiter.sv
logic/mem_bank_array.sv
logic/local_mem_top.sv
test/local_mem_assertions.sv
test/local_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the local memory testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module local_mem_tb \
    -f local_mem_top.f -o local_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/local_mem_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    exit 1
fi
exit 0
